/* source/mtest_consts.svh */
`ifndef MTEST_CONSTS_SVH
`define MTEST_CONSTS_SVH

// command decode window
`define MTEST_ADDR          16'h00f0
`define MTEST_MASK          16'h03f0

// register numbers inside the window
`define MTEST_CHN_A_MODE    4'h4
`define MTEST_CHN_A_STATUS  4'h5
`define MTEST_CHN_B_MODE    4'h6
`define MTEST_CHN_B_STATUS  4'h7

// leading byte of each status packet
`define MTEST_STATUS_A_ADDR 8'h3c
`define MTEST_STATUS_B_ADDR 8'h3d

`define MTEST_PAGE_BITS     4
`define MTEST_LINE_BITS     16

// address byte plus four payload bytes
`define MTEST_STATUS_BYTES  5

`endif

/* source/mtest_pkg.sv */
`include "mtest_consts.svh"

package mtest_pkg;

    typedef struct packed {
        logic [4:0] reserved;
        logic       suspend;
        logic       next_page;
        logic       frame_start;
    } chan_mode_t;

    // mode 0 off, 1 once, 3 once and on every change
    typedef struct packed {
        logic [1:0] mode;
        logic [5:0] seq;
    } status_ctl_t;

    // one data byte read per target register
    typedef union packed {
        chan_mode_t  mode;
        status_ctl_t ctl;
    } cmd_data_u;

    typedef struct packed {
        logic       we;
        logic [3:0] reg_addr;
        cmd_data_u  data;
    } cmd_t;

    typedef struct packed {
        logic                        page_ready;
        logic                        frame_done;
        logic [`MTEST_LINE_BITS-1:0] line_unfinished;
    } chan_in_t;

    typedef struct packed {
        logic frame_start;
        logic next_page;
        logic suspend;
    } chan_out_t;

    typedef struct packed {
        logic [`MTEST_PAGE_BITS-1:0] page;
        logic [`MTEST_LINE_BITS-1:0] line_unfinished;
        logic                        finished;
        logic                        busy;
    } chan_status_t;

    typedef struct packed {
        logic [7:0] ad;
        logic       rq;
    } status_link_t;

endpackage

/* source/cmd_deser.sv */
`include "mtest_consts.svh"

module cmd_deser (
    input  logic            mclk,
    input  logic            rst,
    input  logic [7:0]      cmd_ad,
    input  logic            cmd_stb,
    output mtest_pkg::cmd_t cmd
);
    logic [1:0]  pos;       // 0 idle, 1 high addr, 2 data
    logic [7:0]  addr_lo;
    logic [7:0]  addr_hi;
    logic [15:0] addr;
    logic        hit;
    logic        we_r;
    logic [3:0]  reg_r;
    logic [7:0]  data_r;

    assign addr = {addr_hi, addr_lo};
    assign hit  = ((addr ^ `MTEST_ADDR) & `MTEST_MASK) == 16'h0000;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            pos  <= 2'd0;
            we_r <= 1'b0;
        end else begin
            we_r <= (pos == 2'd2) && hit && !cmd_stb; // one cycle per accepted command
            if (cmd_stb) begin
                pos <= 2'd1;
            end else if (pos == 2'd1) begin
                pos <= 2'd2;
            end else begin
                pos <= 2'd0;
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (cmd_stb) begin
            addr_lo <= cmd_ad;
        end
        if (pos == 2'd1) begin
            addr_hi <= cmd_ad;
        end
        if (pos == 2'd2) begin
            reg_r  <= addr_lo[3:0];
            data_r <= cmd_ad;
        end
    end

    assign cmd.we       = we_r;
    assign cmd.reg_addr = reg_r;
    assign cmd.data     = data_r;

endmodule

/* source/status_packetizer.sv */
`include "mtest_consts.svh"

module status_packetizer #(
    parameter logic [7:0] STATUS_ADDR = `MTEST_STATUS_A_ADDR
) (
    input  logic                    mclk,
    input  logic                    rst,
    input  logic                    ctl_we,
    input  mtest_pkg::status_ctl_t  ctl,
    input  mtest_pkg::chan_status_t status,
    output mtest_pkg::status_link_t link,
    input  logic                    start
);
    localparam logic [2:0] LAST_BYTE = 3'(`MTEST_STATUS_BYTES - 1);

    mtest_pkg::status_ctl_t  ctl_r;
    mtest_pkg::chan_status_t snap;   // payload of the last packet
    logic                    rq_r;
    logic [2:0]              cnt;    // trailing byte index
    logic                    want_r;
    logic                    want;
    logic                    changed;
    logic                    idle;
    logic                    raise;
    logic [7:0]              ad;

    assign idle    = !rq_r && (cnt == 3'd0);
    assign want    = ctl_we ? (ctl.mode != 2'd0) : want_r;
    assign changed = !ctl_we && (ctl_r.mode == 2'd3) && (status != snap);
    assign raise   = idle && (want || changed);

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            ctl_r  <= '0;
            want_r <= 1'b0;
            rq_r   <= 1'b0;
            cnt    <= 3'd0;
        end else begin
            if (ctl_we) begin
                ctl_r <= ctl;
            end
            want_r <= want && !raise; // write seen while a packet is out
            if (raise) begin
                rq_r <= 1'b1;
            end else if (rq_r && start) begin
                rq_r <= 1'b0;
                cnt  <= 3'd1;
            end else if (cnt == LAST_BYTE) begin
                cnt <= 3'd0;
            end else if (cnt != 3'd0) begin
                cnt <= cnt + 3'd1;
            end
        end
    end

    // frozen until the next request
    always_ff @(posedge mclk) begin
        if (raise) begin
            snap <= status;
        end
    end

    always_comb begin
        case (cnt)
            3'd1:    ad = {ctl_r.seq, snap[1:0]};
            3'd2:    ad = snap[9:2];
            3'd3:    ad = snap[17:10];
            3'd4:    ad = snap[25:18];
            default: ad = STATUS_ADDR;  // held while waiting for start
        endcase
    end

    assign link.ad = ad;
    assign link.rq = rq_r;

endmodule

/* source/frame_chan_ctrl.sv */
`include "mtest_consts.svh"

module frame_chan_ctrl #(
    parameter logic [3:0] MODE_REG    = `MTEST_CHN_A_MODE,
    parameter logic [7:0] STATUS_ADDR = `MTEST_STATUS_A_ADDR
) (
    input  logic                    mclk,
    input  logic                    rst,
    input  mtest_pkg::cmd_t         cmd,
    input  mtest_pkg::chan_in_t     chan_in,
    output mtest_pkg::chan_out_t    chan_out,
    output mtest_pkg::status_link_t link,
    input  logic                    start
);
    logic                        mode_we;
    logic                        ctl_we;
    mtest_pkg::chan_mode_t       mode;
    logic                        frame_start_r;
    logic                        next_page_r;
    logic                        suspend_r;
    logic [`MTEST_PAGE_BITS-1:0] page_r;
    logic                        busy_r;
    logic                        finished_r;
    mtest_pkg::chan_status_t     status;

    assign mode_we = cmd.we && (cmd.reg_addr == MODE_REG);
    assign ctl_we  = cmd.we && (cmd.reg_addr == MODE_REG + 4'd1); // status reg follows mode
    assign mode    = cmd.data.mode;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            frame_start_r <= 1'b0;
            next_page_r   <= 1'b0;
            suspend_r     <= 1'b0;
        end else begin
            frame_start_r <= mode_we && mode.frame_start;
            next_page_r   <= mode_we && mode.next_page;
            if (mode_we) begin
                suspend_r <= mode.suspend;
            end
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            page_r <= '0;
        end else if (frame_start_r) begin
            page_r <= '0;
        end else if (chan_in.page_ready) begin
            page_r <= page_r + 1'b1;  // wraps
        end
    end

    // start and done together leave both flags alone
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            busy_r     <= 1'b0;
            finished_r <= 1'b0;
        end else if (frame_start_r && !chan_in.frame_done) begin
            busy_r     <= 1'b1;
            finished_r <= 1'b0;
        end else if (!frame_start_r && chan_in.frame_done) begin
            busy_r     <= 1'b0;
            finished_r <= 1'b1;
        end
    end

    assign chan_out.frame_start = frame_start_r;
    assign chan_out.next_page   = next_page_r;
    assign chan_out.suspend     = suspend_r;

    assign status.page            = page_r;
    assign status.line_unfinished = chan_in.line_unfinished;
    assign status.finished        = finished_r;
    assign status.busy            = busy_r;

    status_packetizer #(
        .STATUS_ADDR (STATUS_ADDR)
    ) u_packetizer (
        .mclk   (mclk),
        .rst    (rst),
        .ctl_we (ctl_we),
        .ctl    (cmd.data.ctl),
        .status (status),
        .link   (link),
        .start  (start)
    );

endmodule

/* source/status_merge.sv */
`include "mtest_consts.svh"

module status_merge (
    input  logic                    mclk,
    input  logic                    rst,
    input  mtest_pkg::status_link_t link_a,
    input  mtest_pkg::status_link_t link_b,
    output logic                    start_a,
    output logic                    start_b,
    output logic [7:0]              status_ad,
    output logic                    status_rq,
    input  logic                    status_start
);
    localparam logic [2:0] LAST_BYTE = 3'(`MTEST_STATUS_BYTES - 1);

    logic       active;   // a packet owns the output
    logic       sel_b;
    logic       prio_a;   // A wins a tie
    logic [2:0] cnt;
    logic       pick_b;
    logic       waiting;

    assign pick_b  = link_b.rq && !(link_a.rq && prio_a);
    assign waiting = active && (cnt == 3'd0);

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
            sel_b  <= 1'b0;
            prio_a <= 1'b1;
            cnt    <= 3'd0;
        end else if (!active) begin
            if (link_a.rq || link_b.rq) begin
                active <= 1'b1;
                sel_b  <= pick_b;
                prio_a <= pick_b;  // the other side goes next
            end
        end else if (cnt == 3'd0) begin
            if (status_start && status_rq) begin
                cnt <= 3'd1;
            end
        end else if (cnt == LAST_BYTE) begin
            cnt    <= 3'd0;
            active <= 1'b0;
        end else begin
            cnt <= cnt + 3'd1;
        end
    end

    assign status_rq = active && (sel_b ? link_b.rq : link_a.rq);
    assign status_ad = sel_b ? link_b.ad : link_a.ad;
    assign start_a   = waiting && !sel_b && status_start;
    assign start_b   = waiting && sel_b && status_start;

endmodule

/* source/mtest_top.sv */
`include "mtest_consts.svh"

module mtest_top (
    input  logic                 mclk,
    input  logic                 rst,
    input  logic [7:0]           cmd_ad,
    input  logic                 cmd_stb,
    output logic [7:0]           status_ad,
    output logic                 status_rq,
    input  logic                 status_start,
    input  mtest_pkg::chan_in_t  chan_a_in,
    output mtest_pkg::chan_out_t chan_a_out,
    input  mtest_pkg::chan_in_t  chan_b_in,
    output mtest_pkg::chan_out_t chan_b_out
);
    mtest_pkg::cmd_t         cmd;
    mtest_pkg::status_link_t link_a;
    mtest_pkg::status_link_t link_b;
    logic                    start_a;
    logic                    start_b;

    cmd_deser u_cmd_deser (
        .mclk    (mclk),
        .rst     (rst),
        .cmd_ad  (cmd_ad),
        .cmd_stb (cmd_stb),
        .cmd     (cmd)
    );

    frame_chan_ctrl #(
        .MODE_REG    (`MTEST_CHN_A_MODE),
        .STATUS_ADDR (`MTEST_STATUS_A_ADDR)
    ) u_chan_a (
        .mclk     (mclk),
        .rst      (rst),
        .cmd      (cmd),
        .chan_in  (chan_a_in),
        .chan_out (chan_a_out),
        .link     (link_a),
        .start    (start_a)
    );

    frame_chan_ctrl #(
        .MODE_REG    (`MTEST_CHN_B_MODE),
        .STATUS_ADDR (`MTEST_STATUS_B_ADDR)
    ) u_chan_b (
        .mclk     (mclk),
        .rst      (rst),
        .cmd      (cmd),
        .chan_in  (chan_b_in),
        .chan_out (chan_b_out),
        .link     (link_b),
        .start    (start_b)
    );

    status_merge u_status_merge (
        .mclk         (mclk),
        .rst          (rst),
        .link_a       (link_a),
        .link_b       (link_b),
        .start_a      (start_a),
        .start_b      (start_b),
        .status_ad    (status_ad),
        .status_rq    (status_rq),
        .status_start (status_start)
    );

endmodule

/* tests/mtest_checker.sv */
module mtest_checker (
    input logic                 mclk,
    input logic                 rst,
    input logic                 status_rq,
    input logic                 status_start,
    input mtest_pkg::chan_out_t chan_a_out,
    input mtest_pkg::chan_out_t chan_b_out
);
    int assert_fails = 0;   // failed assertions so far

    fs_a_single: assert property (@(posedge mclk) disable iff (rst)
        chan_a_out.frame_start |=> !chan_a_out.frame_start)
        else begin
            $error("channel A frame_start high for two cycles");
            assert_fails++;
        end

    np_a_single: assert property (@(posedge mclk) disable iff (rst)
        chan_a_out.next_page |=> !chan_a_out.next_page)
        else begin
            $error("channel A next_page high for two cycles");
            assert_fails++;
        end

    fs_b_single: assert property (@(posedge mclk) disable iff (rst)
        chan_b_out.frame_start |=> !chan_b_out.frame_start)
        else begin
            $error("channel B frame_start high for two cycles");
            assert_fails++;
        end

    np_b_single: assert property (@(posedge mclk) disable iff (rst)
        chan_b_out.next_page |=> !chan_b_out.next_page)
        else begin
            $error("channel B next_page high for two cycles");
            assert_fails++;
        end

    start_with_rq: assert property (@(posedge mclk) disable iff (rst)
        status_start |-> status_rq)
        else begin
            $error("status_start seen while status_rq is low");
            assert_fails++;
        end

    // first cycle out of reset
    rq_low_after_reset: assert property (@(posedge mclk)
        $fell(rst) |-> !status_rq)
        else begin
            $error("status_rq high in the cycle after reset release");
            assert_fails++;
        end

endmodule

bind mtest_top mtest_checker u_checker (
    .mclk         (mclk),
    .rst          (rst),
    .status_rq    (status_rq),
    .status_start (status_start),
    .chan_a_out   (chan_a_out),
    .chan_b_out   (chan_b_out)
);

/* tests/mtest_tb.sv */
`include "mtest_consts.svh"

module mtest_tb;
    logic                 mclk = 1'b0;
    logic                 rst;
    logic [7:0]           cmd_ad;
    logic                 cmd_stb;
    logic [7:0]           status_ad;
    logic                 status_rq;
    logic                 status_start;
    mtest_pkg::chan_in_t  chan_in [2];
    mtest_pkg::chan_out_t chan_out [2];

    logic [31:0] lcg_state = 32'h191aead2;
    logic [39:0] exp_q [$];     // byte 0 in the low bits
    logic [3:0]  page_m [2];
    logic [15:0] line_m [2];
    logic        busy_m [2];
    logic        fin_m [2];
    logic        sus_m [2];
    logic [5:0]  seq_m [2];
    logic        a_next;        // A wins the next tie
    int          min_delay;
    int          mismatches;
    int          failures;

    always #2 mclk = ~mclk;

    mtest_top u_mtest_top (
        .mclk         (mclk),
        .rst          (rst),
        .cmd_ad       (cmd_ad),
        .cmd_stb      (cmd_stb),
        .status_ad    (status_ad),
        .status_rq    (status_rq),
        .status_start (status_start),
        .chan_a_in    (chan_in[0]),
        .chan_a_out   (chan_out[0]),
        .chan_b_in    (chan_in[1]),
        .chan_b_out   (chan_out[1])
    );

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        lcg_next  = lcg_state;
    endfunction

    // address byte, then seq with status 1:0, then the rest of the status upwards
    function logic [39:0] ref_packet(input logic [7:0] addr, input logic [5:0] seq,
                                     input logic [3:0] page, input logic [15:0] line,
                                     input logic fin, input logic busy);
        logic [25:0] p;
        p          = {page, line, fin, busy};
        ref_packet = {p[25:18], p[17:10], p[9:2], seq, p[1:0], addr};
    endfunction

    function logic [15:0] reg_word(input int ch, input logic ctl);
        logic [3:0] r;
        if (ch == 0) begin
            r = ctl ? `MTEST_CHN_A_STATUS : `MTEST_CHN_A_MODE;
        end else begin
            r = ctl ? `MTEST_CHN_B_STATUS : `MTEST_CHN_B_MODE;
        end
        reg_word = `MTEST_ADDR | {12'h000, r};
    endfunction

    task finish_run();
        failures = failures + u_mtest_top.u_checker.assert_fails;
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    task push_expected(input int ch);
        logic [7:0] addr;
        addr = (ch == 0) ? `MTEST_STATUS_A_ADDR : `MTEST_STATUS_B_ADDR;
        exp_q.push_back(ref_packet(addr, seq_m[ch], page_m[ch], line_m[ch],
                                   fin_m[ch], busy_m[ch]));
        a_next = (ch == 1);
    endtask

    task push_tie();
        if (a_next) begin
            push_expected(0);
            push_expected(1);
        end else begin
            push_expected(1);
            push_expected(0);
        end
    endtask

    // low address, high address, data; returns on the edge that samples data
    task send_cmd(input logic [15:0] addr, input logic [7:0] data);
        @(posedge mclk);
        cmd_stb <= 1'b1;
        cmd_ad  <= addr[7:0];
        @(posedge mclk);
        cmd_stb <= 1'b0;
        cmd_ad  <= addr[15:8];
        @(posedge mclk);
        cmd_ad <= data;
        @(posedge mclk);
        cmd_ad <= 8'h00;
    endtask

    task check_outs(input int ch, input logic [1:0] pl);
        int         c;
        logic [2:0] want;
        for (c = 0; c < 2; c++) begin
            want = (c == ch) ? {pl[0], pl[1], sus_m[c]} : {2'b00, sus_m[c]};
            if (chan_out[c] !== want) begin
                mismatches++;
                $display("Mismatch at %0t: channel %0d outputs %b, expected %b",
                         $time, c, chan_out[c], want);
            end
        end
    endtask

    task mode_write(input int ch, input logic [7:0] val);
        int k;
        send_cmd(reg_word(ch, 1'b0), val);
        for (k = 0; k < 3; k++) begin
            @(negedge mclk);
            if (k == 1) begin
                sus_m[ch] = val[2];
            end
            check_outs(ch, (k == 1) ? val[1:0] : 2'b00);   // pulse on the middle cycle
        end
        if (val[0]) begin
            page_m[ch] = 4'd0;
            busy_m[ch] = 1'b1;
            fin_m[ch]  = 1'b0;
        end
    endtask

    task ctl_write(input int ch, input logic [1:0] mode, input logic [5:0] seq);
        seq_m[ch] = seq;
        send_cmd(reg_word(ch, 1'b1), {mode, seq});
    endtask

    task quiet(input int n);
        repeat (n) begin
            @(negedge mclk);
            check_outs(2, 2'b00);
        end
    endtask

    task set_line(input int ch, input logic [15:0] v);
        @(posedge mclk);
        chan_in[ch].line_unfinished <= v;
        line_m[ch] = v;
    endtask

    task pulse_inputs(input logic [1:0] pr, input logic [1:0] fd);
        int c;
        @(posedge mclk);
        for (c = 0; c < 2; c++) begin
            chan_in[c].page_ready <= pr[c];
            chan_in[c].frame_done <= fd[c];
            page_m[c] = page_m[c] + pr[c];
            if (fd[c]) begin
                busy_m[c] = 1'b0;
                fin_m[c]  = 1'b1;
            end
        end
        @(posedge mclk);
        for (c = 0; c < 2; c++) begin
            chan_in[c].page_ready <= 1'b0;
            chan_in[c].frame_done <= 1'b0;
        end
    endtask

    task wait_drain(input int limit);
        int t;
        t = 0;
        while ((exp_q.size() != 0 || status_rq === 1'b1) && t < limit) begin
            @(negedge mclk);
            t++;
        end
        if (exp_q.size() != 0 || status_rq === 1'b1) begin
            failures++;
            $display("Timeout: status port busy after %0d cycles, %0d packets missing",
                     limit, exp_q.size());
            exp_q.delete();
        end
    endtask

    // status port consumer with a random start delay
    initial begin : capture
        int          delay;
        int          i;
        logic [7:0]  got [5];
        logic [39:0] exp_w;
        status_start = 1'b0;
        forever begin
            @(negedge mclk);
            if (status_rq === 1'b1) begin
                delay = min_delay + int'(lcg_next() % 4);
                repeat (delay) @(posedge mclk);
                @(posedge mclk);
                status_start <= 1'b1;
                @(negedge mclk);
                got[0] = status_ad;
                if (status_rq !== 1'b1) begin
                    failures++;
                    $display("status_rq dropped before start at %0t", $time);
                end
                @(posedge mclk);
                status_start <= 1'b0;
                for (i = 1; i < `MTEST_STATUS_BYTES; i++) begin
                    @(negedge mclk);
                    got[i] = status_ad;
                    if (i == 1 && status_rq !== 1'b0) begin
                        failures++;
                        $display("status_rq still high after start at %0t", $time);
                    end
                end
                if (exp_q.size() == 0) begin
                    failures++;
                    $display("Unexpected status packet at %0t, address byte %h", $time, got[0]);
                end else begin
                    exp_w = exp_q.pop_front();
                    for (i = 0; i < `MTEST_STATUS_BYTES; i++) begin
                        if (got[i] !== exp_w[8*i +: 8]) begin
                            mismatches++;
                            $display("Mismatch at %0t: status byte %0d is %h, expected %h",
                                     $time, i, got[i], exp_w[8*i +: 8]);
                        end
                    end
                end
            end
        end
    end

    initial begin : main
        int          n;
        int          c;
        logic [31:0] r;
        rst        = 1'b1;
        cmd_ad     = 8'h00;
        cmd_stb    = 1'b0;
        a_next     = 1'b1;
        min_delay  = 0;
        mismatches = 0;
        failures   = 0;
        for (c = 0; c < 2; c++) begin
            chan_in[c] = '0;
            page_m[c]  = 4'd0;
            line_m[c]  = 16'h0000;
            busy_m[c]  = 1'b0;
            fin_m[c]   = 1'b0;
            sus_m[c]   = 1'b0;
            seq_m[c]   = 6'd0;
        end
        repeat (2) @(posedge mclk);
        rst <= 1'b0;

        mode_write(0, 8'h05);           // frame start with suspend
        mode_write(1, 8'h02);
        mode_write(0, 8'h00);

        send_cmd(16'h0174, 8'h07);      // outside the window
        quiet(6);
        send_cmd(16'h02f5, 8'h41);
        quiet(12);

        mode_write(0, 8'h01);
        n = 1 + int'(lcg_next() % 40);
        repeat (n) begin
            @(posedge mclk);
            r = lcg_next();
            chan_in[0].page_ready <= r[16];
            page_m[0] = page_m[0] + r[16];
        end
        @(posedge mclk);
        chan_in[0].page_ready <= 1'b0;
        r = lcg_next();
        set_line(0, r[31:16]);
        pulse_inputs(2'b00, 2'b01);
        ctl_write(0, 2'd1, r[5:0]);
        push_expected(0);
        wait_drain(200);

        min_delay = 12;                 // payload moves while start is held off
        r = lcg_next();
        ctl_write(0, 2'd1, r[13:8]);
        push_expected(0);
        set_line(0, r[31:16]);
        pulse_inputs(2'b01, 2'b00);
        wait_drain(200);
        min_delay = 0;

        r = lcg_next();
        ctl_write(0, 2'd1, r[5:0]);
        ctl_write(1, 2'd1, r[11:6]);
        push_expected(0);
        push_expected(1);
        wait_drain(200);

        r = lcg_next();
        ctl_write(0, 2'd3, r[5:0]);
        push_expected(0);
        wait_drain(200);
        ctl_write(1, 2'd3, r[11:6]);
        push_expected(1);
        wait_drain(200);
        pulse_inputs(2'b11, 2'b00);     // both change together
        push_tie();
        wait_drain(200);
        mode_write(0, 8'h01);
        push_expected(0);
        wait_drain(200);
        pulse_inputs(2'b11, 2'b00);
        push_tie();
        wait_drain(200);

        ctl_write(0, 2'd0, 6'd0);
        ctl_write(1, 2'd0, 6'd0);
        pulse_inputs(2'b11, 2'b11);
        quiet(20);
        wait_drain(50);
        finish_run();
    end

endmodule

/* mtest_top.f */
+incdir+source
source/mtest_pkg.sv
source/cmd_deser.sv
source/status_packetizer.sv
source/frame_chan_ctrl.sv
source/status_merge.sv
source/mtest_top.sv
tests/mtest_checker.sv
tests/mtest_tb.sv
